// File: hw/video_pkg.sv
package video_pkg;

    // Pixel colour index and palette entry widths
    localparam int COLOUR_W = 4;
    localparam int RGB_W = 12;

    // CPU bus
    localparam int WB_ADR_W = 8;
    localparam int WB_DAT_W = 16;

    // Tiles and sprites share the same square size
    localparam int TILE_SIZE = 8;

    // One sprite where colour 0 disables it
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic [COLOUR_W-1:0] colour;
    } obj_entry_t;

    // Register block address map
    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_TILEMAP,
        REGION_OBJ,
        REGION_PAL,
        REGION_CTRL
    } reg_region_e;

endpackage

// File: hw/video_cfg_if.sv
`timescale 1ns/1ps

interface video_cfg_if #(
    parameter int OBJ_COUNT = 4,
    parameter int MAP_AW = 6
);
    // Control state
    logic flip;
    logic [7:0] scroll_x;
    video_pkg::obj_entry_t [OBJ_COUNT-1:0] obj_table;

    // Tile map read port
    logic [MAP_AW-1:0] tile_addr;
    logic [video_pkg::COLOUR_W-1:0] tile_data;

    // Palette read port
    logic [video_pkg::COLOUR_W-1:0] pal_addr;
    logic [video_pkg::RGB_W-1:0] pal_data;

    modport regs (
        output flip, scroll_x, obj_table, tile_data, pal_data,
        input tile_addr, pal_addr
    );

    modport tiles (
        output tile_addr,
        input tile_data, flip, scroll_x
    );

    modport colmix (
        output pal_addr,
        input pal_data
    );

endinterface

// File: hw/video_regs.sv
`timescale 1ns/1ps

module video_regs #(
    parameter int OBJ_COUNT = 4,
    parameter int MAP_AW = 6
) (
    input  logic clk,
    input  logic rst_n,
    input  logic [video_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [video_pkg::WB_DAT_W-1:0] wb_dat_w,
    input  logic wb_we,
    input  logic wb_stb,
    input  logic wb_cyc,
    output logic [video_pkg::WB_DAT_W-1:0] wb_dat_r,
    output logic wb_ack,
    video_cfg_if.regs cfg
);

    localparam int AW = video_pkg::WB_ADR_W;
    localparam int DW = video_pkg::WB_DAT_W;
    localparam int CW = video_pkg::COLOUR_W;
    localparam int OBJ_IW = (OBJ_COUNT > 1) ? $clog2(OBJ_COUNT) : 1;

    localparam logic [AW-1:0] OBJ_BASE = 8'h40;
    localparam logic [AW-1:0] OBJ_END = AW'(8'h40 + 3 * OBJ_COUNT);
    localparam logic [AW-1:0] PAL_BASE = 8'h50;
    localparam logic [AW-1:0] PAL_END = 8'h60;
    localparam logic [AW-1:0] CTRL_FLIP = 8'h60;
    localparam logic [AW-1:0] CTRL_SCROLL = 8'h61;

    logic [CW-1:0] tile_map [2**MAP_AW];
    logic [video_pkg::RGB_W-1:0] palette [2**CW];
    video_pkg::obj_entry_t [OBJ_COUNT-1:0] obj_table;
    logic flip;
    logic [7:0] scroll_x;

    video_pkg::reg_region_e region;
    logic [AW-1:0] obj_off;
    logic [OBJ_IW-1:0] obj_idx;
    logic [1:0] obj_field;
    logic [DW-1:0] rd_data;
    logic req;

    // New request only when the previous one is not being acked
    assign req = wb_stb && wb_cyc && !wb_ack;

    always_comb begin
        if (wb_adr < OBJ_BASE) begin
            region = video_pkg::REGION_TILEMAP;
        end else if (wb_adr < OBJ_END) begin
            region = video_pkg::REGION_OBJ;
        end else if (wb_adr >= PAL_BASE && wb_adr < PAL_END) begin
            region = video_pkg::REGION_PAL;
        end else if (wb_adr == CTRL_FLIP || wb_adr == CTRL_SCROLL) begin
            region = video_pkg::REGION_CTRL;
        end else begin
            region = video_pkg::REGION_NONE;
        end
    end

    // Three words per object for x, y and colour
    assign obj_off = wb_adr - OBJ_BASE;
    assign obj_idx = OBJ_IW'(obj_off / 3);
    assign obj_field = 2'(obj_off % 3);

    always_comb begin
        rd_data = '0;
        case (region)
            video_pkg::REGION_TILEMAP: rd_data = DW'(tile_map[wb_adr[MAP_AW-1:0]]);
            video_pkg::REGION_OBJ: begin
                case (obj_field)
                    2'd0: rd_data = DW'(obj_table[obj_idx].x);
                    2'd1: rd_data = DW'(obj_table[obj_idx].y);
                    default: rd_data = DW'(obj_table[obj_idx].colour);
                endcase
            end
            video_pkg::REGION_PAL: rd_data = DW'(palette[wb_adr[CW-1:0]]);
            video_pkg::REGION_CTRL: rd_data = wb_adr[0] ? DW'(scroll_x) : DW'(flip);
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            wb_dat_r <= '0;
            flip <= 1'b0;
            scroll_x <= '0;
            obj_table <= '0;
            for (int i = 0; i < 2**MAP_AW; i++) begin
                tile_map[i] <= '0;
            end
            for (int i = 0; i < 2**CW; i++) begin
                palette[i] <= '0;
            end
        end else begin
            wb_ack <= req;
            if (req) begin
                wb_dat_r <= rd_data;
                if (wb_we) begin
                    case (region)
                        video_pkg::REGION_TILEMAP:
                            tile_map[wb_adr[MAP_AW-1:0]] <= wb_dat_w[CW-1:0];
                        video_pkg::REGION_OBJ: begin
                            case (obj_field)
                                2'd0: obj_table[obj_idx].x <= wb_dat_w[7:0];
                                2'd1: obj_table[obj_idx].y <= wb_dat_w[7:0];
                                default: obj_table[obj_idx].colour <= wb_dat_w[CW-1:0];
                            endcase
                        end
                        video_pkg::REGION_PAL:
                            palette[wb_adr[CW-1:0]] <= wb_dat_w[video_pkg::RGB_W-1:0];
                        video_pkg::REGION_CTRL: begin
                            if (wb_adr[0]) begin
                                scroll_x <= wb_dat_w[7:0];
                            end else begin
                                flip <= wb_dat_w[0];
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // Combinational read ports for the layers
    assign cfg.tile_data = tile_map[cfg.tile_addr];
    assign cfg.pal_data = palette[cfg.pal_addr];
    assign cfg.flip = flip;
    assign cfg.scroll_x = scroll_x;
    assign cfg.obj_table = obj_table;

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

// File: hw/video_timer.sv
`timescale 1ns/1ps

module video_timer #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL = 80,
    parameter int V_ACTIVE = 48,
    parameter int V_TOTAL = 56
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pxl_cen,
    output logic [7:0] hdump,
    output logic [7:0] vdump,
    output logic lhbl,
    output logic lvbl,
    output logic hs,
    output logic vs
);

    localparam logic [7:0] H_LAST = 8'(H_TOTAL - 1);
    localparam logic [7:0] V_LAST = 8'(V_TOTAL - 1);
    // Sync pulses sit at the very end of the line and frame
    localparam logic [7:0] HS_START = 8'(H_TOTAL - 4);
    localparam logic [7:0] VS_START = 8'(V_TOTAL - 2);

    logic [7:0] h_next;
    logic [7:0] v_next;

    always_comb begin
        h_next = hdump + 8'd1;
        v_next = vdump;
        if (hdump == H_LAST) begin
            h_next = '0;
            v_next = (vdump == V_LAST) ? 8'd0 : vdump + 8'd1;
        end
    end

    // Flags come from the next count so they line up with the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= '0;
            vdump <= '0;
            lhbl <= 1'b1;
            lvbl <= 1'b1;
            hs <= 1'b0;
            vs <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            lhbl <= h_next < 8'(H_ACTIVE);
            lvbl <= v_next < 8'(V_ACTIVE);
            hs <= h_next >= HS_START;
            vs <= v_next >= VS_START;
        end
    end

    hdump_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        hdump < 8'(H_TOTAL));

endmodule

// File: hw/video_tiles.sv
`timescale 1ns/1ps

module video_tiles #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 48
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pxl_cen,
    input  logic [7:0] hdump,
    input  logic [7:0] vdump,
    video_cfg_if.tiles cfg,
    output logic [video_pkg::COLOUR_W-1:0] tile_pxl
);

    localparam int COLS = H_ACTIVE / video_pkg::TILE_SIZE;
    localparam int ROWS = V_ACTIVE / video_pkg::TILE_SIZE;
    localparam int MAP_AW = $clog2(COLS * ROWS);

    logic [7:0] scr_x;
    logic [7:0] scr_y;
    logic [8:0] sum_x;
    logic [7:0] map_x;
    logic [7:0] col;
    logic [7:0] row;

    // Mirror both axes when the screen is flipped
    assign scr_x = cfg.flip ? 8'(H_ACTIVE - 1) - hdump : hdump;
    assign scr_y = cfg.flip ? 8'(V_ACTIVE - 1) - vdump : vdump;

    // Scroll wraps around the visible width
    assign sum_x = {1'b0, scr_x} + {1'b0, cfg.scroll_x};
    assign map_x = 8'(sum_x % 9'(H_ACTIVE));

    assign col = map_x / 8'(video_pkg::TILE_SIZE);
    assign row = scr_y / 8'(video_pkg::TILE_SIZE);
    assign cfg.tile_addr = MAP_AW'(row * 8'(COLS) + col);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_pxl <= '0;
        end else if (pxl_cen) begin
            tile_pxl <= cfg.tile_data;
        end
    end

endmodule

// File: hw/video_objs.sv
`timescale 1ns/1ps

module video_objs #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 48,
    parameter int OBJ_COUNT = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pxl_cen,
    input  logic [7:0] hdump,
    input  logic [7:0] vdump,
    input  logic flip,
    input  video_pkg::obj_entry_t [OBJ_COUNT-1:0] obj_table,
    output logic [video_pkg::COLOUR_W-1:0] obj_pxl
);

    localparam logic [8:0] OBJ_SIZE = 9'(video_pkg::TILE_SIZE);

    logic [7:0] scr_x;
    logic [7:0] scr_y;
    logic [video_pkg::COLOUR_W-1:0] hit_colour;

    assign scr_x = flip ? 8'(H_ACTIVE - 1) - hdump : hdump;
    assign scr_y = flip ? 8'(V_ACTIVE - 1) - vdump : vdump;

    // Walk from the top entry down so the lowest index wins
    always_comb begin
        hit_colour = '0;
        for (int i = OBJ_COUNT - 1; i >= 0; i--) begin
            if (obj_table[i].colour != '0
                    && scr_x >= obj_table[i].x
                    && {1'b0, scr_x} < {1'b0, obj_table[i].x} + OBJ_SIZE
                    && scr_y >= obj_table[i].y
                    && {1'b0, scr_y} < {1'b0, obj_table[i].y} + OBJ_SIZE) begin
                hit_colour = obj_table[i].colour;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            obj_pxl <= '0;
        end else if (pxl_cen) begin
            obj_pxl <= hit_colour;
        end
    end

endmodule

// File: hw/video_colmix.sv
`timescale 1ns/1ps

module video_colmix (
    input  logic clk,
    input  logic rst_n,
    input  logic pxl_cen,
    input  logic [video_pkg::COLOUR_W-1:0] tile_pxl,
    input  logic [video_pkg::COLOUR_W-1:0] obj_pxl,
    input  logic lhbl,
    input  logic lvbl,
    video_cfg_if.colmix cfg,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue,
    output logic lhbl_dly,
    output logic lvbl_dly
);

    // Blanks aligned with the layer outputs
    logic lhbl_d1;
    logic lvbl_d1;

    // Objects always sit on top of the tile layer
    assign cfg.pal_addr = (obj_pxl != '0) ? obj_pxl : tile_pxl;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d1 <= 1'b0;
            lvbl_d1 <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            {red, green, blue} <= '0;
        end else if (pxl_cen) begin
            lhbl_d1 <= lhbl;
            lvbl_d1 <= lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            if (lhbl_d1 && lvbl_d1) begin
                {red, green, blue} <= cfg.pal_data;
            end else begin
                {red, green, blue} <= '0;
            end
        end
    end

    rgb_dark_in_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !(lhbl_dly && lvbl_dly) |-> {red, green, blue} == '0);

endmodule

// File: hw/video_top.sv
`timescale 1ns/1ps

module video_top #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL = 80,
    parameter int V_ACTIVE = 48,
    parameter int V_TOTAL = 56,
    parameter int OBJ_COUNT = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pxl_cen,
    input  logic [video_pkg::WB_ADR_W-1:0] wb_adr,
    input  logic [video_pkg::WB_DAT_W-1:0] wb_dat_w,
    output logic [video_pkg::WB_DAT_W-1:0] wb_dat_r,
    input  logic wb_we,
    input  logic wb_stb,
    input  logic wb_cyc,
    output logic wb_ack,
    output logic hs,
    output logic vs,
    output logic lhbl_dly,
    output logic lvbl_dly,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    // Tile map address width from the visible tile grid
    localparam int MAP_AW = $clog2((H_ACTIVE / video_pkg::TILE_SIZE)
                                   * (V_ACTIVE / video_pkg::TILE_SIZE));

    logic [7:0] hdump;
    logic [7:0] vdump;
    logic lhbl;
    logic lvbl;
    logic [video_pkg::COLOUR_W-1:0] tile_pxl;
    logic [video_pkg::COLOUR_W-1:0] obj_pxl;

    video_cfg_if #(.OBJ_COUNT(OBJ_COUNT), .MAP_AW(MAP_AW)) cfg_if ();

    video_regs #(.OBJ_COUNT(OBJ_COUNT), .MAP_AW(MAP_AW)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg_if.regs)
    );

    video_timer #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .lhbl    (lhbl),
        .lvbl    (lvbl),
        .hs      (hs),
        .vs      (vs)
    );

    video_tiles #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_tiles (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .cfg      (cfg_if.tiles),
        .tile_pxl (tile_pxl)
    );

    video_objs #(
        .H_ACTIVE  (H_ACTIVE),
        .V_ACTIVE  (V_ACTIVE),
        .OBJ_COUNT (OBJ_COUNT)
    ) u_objs (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .hdump     (hdump),
        .vdump     (vdump),
        .flip      (cfg_if.flip),
        .obj_table (cfg_if.obj_table),
        .obj_pxl   (obj_pxl)
    );

    video_colmix u_colmix (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .tile_pxl (tile_pxl),
        .obj_pxl  (obj_pxl),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .cfg      (cfg_if.colmix),
        .red      (red),
        .green    (green),
        .blue     (blue),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

// File: test/video_tb.sv
`timescale 1ns/1ps

module video_tb;

    localparam int H_ACTIVE = 64;
    localparam int H_TOTAL = 80;
    localparam int V_ACTIVE = 48;
    localparam int V_TOTAL = 56;
    localparam int OBJ_COUNT = 4;
    localparam int TILE = 8;
    localparam int MAP_COLS = H_ACTIVE / TILE;
    localparam int HS_LEN = 4;
    localparam int VS_LEN = 2;
    localparam int PIPE_DELAY = 2;
    localparam int ACK_TIMEOUT = 16;
    localparam int TICK_TIMEOUT = 8;
    localparam int FRAME_TICKS = 2 * H_TOTAL * V_TOTAL;
    localparam logic [31:0] SEED = 32'hada2_1c1c;

    logic clk = 1'b0;
    logic rst_n;
    logic pxl_cen;
    logic [7:0] wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic wb_we;
    logic wb_stb;
    logic wb_cyc;
    logic wb_ack;
    logic hs;
    logic vs;
    logic lhbl_dly;
    logic lvbl_dly;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    // Shadow of everything written over the bus
    logic [3:0] tile_shadow [64];
    logic [11:0] pal_shadow [16];
    int obj_x [OBJ_COUNT];
    int obj_y [OBJ_COUNT];
    int obj_colour [OBJ_COUNT];
    logic flip_shadow;
    int scroll_shadow;

    video_top #(
        .H_ACTIVE  (H_ACTIVE),
        .H_TOTAL   (H_TOTAL),
        .V_ACTIVE  (V_ACTIVE),
        .V_TOTAL   (V_TOTAL),
        .OBJ_COUNT (OBJ_COUNT)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .wb_ack   (wb_ack),
        .hs       (hs),
        .vs       (vs),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    always #20 clk = ~clk;

    // Pixel enable on every second clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping after first error");
    endtask

    task automatic check_failed(input string what);
        abort_run($sformatf("CHECK FAILED at time %0t: %s", $time, what));
    endtask

    // One Wishbone classic cycle with outputs sampled on the falling edge
    task automatic bus_cycle(input logic [7:0] adr, input logic [15:0] wdata,
                             input logic we, output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        wb_adr <= adr;
        wb_dat_w <= wdata;
        wb_we <= we;
        wb_stb <= 1'b1;
        wb_cyc <= 1'b1;
        @(negedge clk);
        while (!wb_ack) begin
            if (waited >= ACK_TIMEOUT) begin
                abort_run($sformatf("No wb_ack for the cycle at address %h", adr));
            end
            @(negedge clk);
            waited++;
        end
        rdata = wb_dat_r;
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_cyc <= 1'b0;
        wb_we <= 1'b0;
        @(negedge clk);
        assert (!wb_ack) else check_failed($sformatf("wb_ack longer than one cycle at %h", adr));
    endtask

    task automatic apply_write(input logic [7:0] adr, input logic [15:0] data);
        int off;
        off = int'(adr) - 'h40;
        if (adr < 8'h40) begin
            tile_shadow[adr[5:0]] = data[3:0];
        end else if (off < 3 * OBJ_COUNT) begin
            case (off % 3)
                0: obj_x[off / 3] = int'(data[7:0]);
                1: obj_y[off / 3] = int'(data[7:0]);
                default: obj_colour[off / 3] = int'(data[3:0]);
            endcase
        end else if (adr >= 8'h50 && adr < 8'h60) begin
            pal_shadow[adr[3:0]] = data[11:0];
        end else if (adr == 8'h60) begin
            flip_shadow = data[0];
        end else if (adr == 8'h61) begin
            scroll_shadow = int'(data[7:0]);
        end
    endtask

    // Expected colour of visible pixel (x, y)
    function automatic logic [11:0] model_pixel(input int x, input int y);
        int sx;
        int sy;
        int idx;
        bit found;
        sx = flip_shadow ? H_ACTIVE - 1 - x : x;
        sy = flip_shadow ? V_ACTIVE - 1 - y : y;
        idx = int'(tile_shadow[(sy / TILE) * MAP_COLS + ((sx + scroll_shadow) % H_ACTIVE) / TILE]);
        found = 1'b0;
        for (int i = 0; i < OBJ_COUNT; i++) begin
            if (!found && obj_colour[i] != 0 && sx >= obj_x[i] && sx < obj_x[i] + TILE
                    && sy >= obj_y[i] && sy < obj_y[i] + TILE) begin
                idx = obj_colour[i];
                found = 1'b1;
            end
        end
        return pal_shadow[idx];
    endfunction

    // Exactly one pixel tick, outputs sampled on the following falling edge
    task automatic wait_tick();
        int n;
        n = 0;
        @(posedge clk);
        while (!pxl_cen) begin
            if (n >= TICK_TIMEOUT) begin
                abort_run("pxl_cen stayed low, no pixel tick arrived");
            end
            @(posedge clk);
            n++;
        end
        @(negedge clk);
    endtask

    // Timer position follows the ticks
    task automatic step_pixel(inout int h, inout int v);
        wait_tick();
        h++;
        if (h == H_TOTAL) begin
            h = 0;
            v++;
        end
    endtask

    // Sync pulses cover the last pixels of a line and the last lines of a frame
    task automatic check_sync(input int h, input int v);
        logic want_hs;
        logic want_vs;
        want_hs = h >= H_TOTAL - HS_LEN;
        want_vs = (v % V_TOTAL) >= V_TOTAL - VS_LEN;
        assert (hs == want_hs && vs == want_vs)
            else check_failed($sformatf("hs %b vs %b at line %0d pixel %0d, expected %b %b",
                                        hs, vs, v, h, want_hs, want_vs));
    endtask

    task automatic check_frame();
        int x;
        int y;
        int h;
        int v;
        int ticks;
        logic prev_v;
        logic prev_h;
        logic [11:0] got;
        logic [11:0] want;
        prev_v = 1'b1;
        ticks = 0;
        // Skip to the first valid pixel of the next frame
        while (!(lvbl_dly && !prev_v)) begin
            if (ticks > FRAME_TICKS) begin
                abort_run("Timeout waiting for lvbl_dly to rise");
            end
            got = {red, green, blue};
            assert ((lhbl_dly && lvbl_dly) || got == 12'h000)
                else check_failed($sformatf("rgb %h during blanking", got));
            prev_v = lvbl_dly;
            wait_tick();
            ticks++;
        end
        // Timer is two pixels ahead of the first valid pixel
        h = PIPE_DELAY;
        v = 0;
        x = 0;
        y = 0;
        ticks = 0;
        prev_h = 1'b0;
        while (lvbl_dly) begin
            if (ticks > FRAME_TICKS) begin
                abort_run("Timeout waiting for lvbl_dly to fall");
            end
            got = {red, green, blue};
            check_sync(h, v);
            if (lhbl_dly) begin
                assert (x < H_ACTIVE && y < V_ACTIVE)
                    else check_failed($sformatf("extra valid pixel at (%0d,%0d)", x, y));
                want = model_pixel(x, y);
                assert (got == want)
                    else check_failed($sformatf("pixel (%0d,%0d) rgb %h, expected %h",
                                                x, y, got, want));
                x++;
            end else begin
                assert (got == 12'h000)
                    else check_failed($sformatf("rgb %h in horizontal blanking", got));
                if (prev_h) begin
                    assert (x == H_ACTIVE)
                        else check_failed($sformatf("line %0d has %0d valid pixels", y, x));
                    x = 0;
                    y++;
                end
            end
            prev_h = lhbl_dly;
            step_pixel(h, v);
            ticks++;
        end
        assert (y == V_ACTIVE) else check_failed($sformatf("frame has %0d visible lines", y));
        // Vertical blanking up to the start of the next frame
        while (v < V_TOTAL) begin
            got = {red, green, blue};
            assert (!lvbl_dly && got == 12'h000)
                else check_failed($sformatf("lvbl_dly %b rgb %h in vertical blanking",
                                            lvbl_dly, got));
            check_sync(h, v);
            step_pixel(h, v);
        end
        check_sync(h, v);
    endtask

    initial begin
        int fd;
        int n;
        int seed_ret;
        string line;
        logic [7:0] cmd;
        logic [15:0] adr;
        logic [15:0] data;
        logic [15:0] rdata;
        rst_n = 1'b0;
        pxl_cen = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_we = 1'b0;
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        for (int i = 0; i < 64; i++) begin
            tile_shadow[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            pal_shadow[i] = '0;
        end
        for (int i = 0; i < OBJ_COUNT; i++) begin
            obj_x[i] = 0;
            obj_y[i] = 0;
            obj_colour[i] = 0;
        end
        flip_shadow = 1'b0;
        scroll_shadow = 0;
        adr = '0;
        data = '0;
        seed_ret = $urandom(SEED);
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("test/video_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open test/video_testdata.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            cmd = " ";
            if (n > 0) begin
                n = $sscanf(line, "%c %h %h", cmd, adr, data);
            end
            case (cmd)
                "W": begin
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    bus_cycle(adr[7:0], data, 1'b1, rdata);
                    apply_write(adr[7:0], data);
                end
                "R": begin
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    bus_cycle(adr[7:0], 16'h0000, 1'b0, rdata);
                    assert (rdata == data)
                        else check_failed($sformatf("read %h from address %h, expected %h",
                                                    rdata, adr[7:0], data));
                end
                "F": check_frame();
                "#", " ", "\n", "\r": ;
                default: abort_run($sformatf("Unknown command in test data: %s", line));
            endcase
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: test/video_testdata.txt
# W addr data: bus write; R addr expected: bus read and compare; F: full frame check
# Hex values. Tiles 00-3F, objects 40-4B as x y colour, palette 50-5F, 60 flip, 61 scroll
W 50 0111
W 51 0F00
W 52 00F0
W 53 000F
W 55 0ABC
W 00 0001
W 09 0002
W 12 00F3
W 2F 0005
R 12 0003
R 55 0ABC
R 70 0000
F
W 61 0014
R 61 0014
F
W 40 0004
W 41 0006
W 42 0003
W 43 0008
W 44 0008
W 45 0005
W 49 003C
W 4A 002C
W 4B 0002
R 44 0008
F
W 60 0001
R 60 0001
F

// File: compile.f
hw/video_pkg.sv
hw/video_cfg_if.sv
hw/video_regs.sv
hw/video_timer.sv
hw/video_tiles.sv
hw/video_objs.sv
hw/video_colmix.sv
hw/video_top.sv
test/video_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= video_tb
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' compile.f)
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) compile.f test/video_testdata.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f compile.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || (echo "FAIL, see $(LOG)"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
